//--- vlog.f
+incdir+include
verilog/sdr_test_pkg.sv
verilog/sdr_test_ctrl.sv
verilog/sdr_pattern_gen.sv
verilog/sdr_read_issue.sv
verilog/sdr_read_check.sv
verilog/sdr_test_top.sv
tb/tb_clk_gen.sv
tb/tb_sdr_test.sv

//--- Makefile
SIM      = verilator
TOP      = tb_sdr_test
FILELIST = vlog.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert --top-module $(TOP) -Mdir $(OBJDIR)
PASS_MSG = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

//--- tb/tb_sdr_test.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdr_test_consts.svh"

module tb_sdr_test;
    logic                       Clk;
    logic                       arst_n;
    logic                       start;
    logic                       init_done;
    logic                       ref_busy;
    logic                       rd_valid;
    logic [`SDR_DATA_WIDTH-1:0] rd_data;
    logic                       wr_en;
    logic [`SDR_ADDR_WIDTH-1:0] wr_addr;
    logic [`SDR_DATA_WIDTH-1:0] wr_data;
    logic                       rd_en;
    logic [`SDR_ADDR_WIDTH-1:0] rd_addr;
    logic                       busy;
    logic                       done;
    logic                       pass_ok;
    logic [`SDR_CNT_WIDTH-1:0]  data_err_cnt;
    logic [`SDR_CNT_WIDTH-1:0]  tag_err_cnt;
    logic [`SDR_ADDR_WIDTH-1:0] first_err_addr;
    logic                       timed_out;

    // memory model state
    logic [`SDR_DATA_WIDTH-1:0] mem [0:`SDR_TEST_WORDS-1];
    int          rq_addr[$];
    int          rq_due[$];
    int          last_due;
    int          ref_left;
    logic [31:0] lfsr;
    logic        ref_busy_q;
    // 0 clean, 1 seq corrupt, 2 tag corrupt, 3 dropped return
    int          mode;
    // testbench view of the pass
    int          cyc;
    int          errors;
    int          wr_cnt;
    int          rd_cnt;
    int          last_rv_cyc;
    bit          cur_odd;
    bit          next_odd;
    bit          pass_done;
    bit          aborted;
    int          exp_data_err;
    int          exp_tag_err;
    int          exp_first;
    bit          exp_timeout;

    tb_clk_gen u_clk_gen (.Clk(Clk), .arst_n(arst_n));

    sdr_test_top u_sdr_test_top
    (
        .Clk(Clk), .arst_n(arst_n), .start(start), .init_done(init_done),
        .ref_busy(ref_busy), .rd_valid(rd_valid), .rd_data(rd_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .rd_en(rd_en),
        .rd_addr(rd_addr), .busy(busy), .done(done), .pass_ok(pass_ok),
        .data_err_cnt(data_err_cnt), .tag_err_cnt(tag_err_cnt),
        .first_err_addr(first_err_addr), .timed_out(timed_out)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int take_bits(int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // tag is the low address bits, seq inverted on odd passes
    function automatic logic [31:0] pattern_for(int idx, bit odd);
        logic [15:0] tag;
        tag = idx[15:0];
        return {tag, odd ? ~tag : tag};
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act)
        else
        begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(bit cond, string what);
        assert (cond)
        else
        begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model and monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge Clk)
    begin
        int          a;
        int          lat;
        logic [31:0] d;
        bit          drop;
        if (arst_n)
        begin
            cyc++;
            if (start)
            begin
                cur_odd  = next_odd;
                next_odd = ~next_odd;
                wr_cnt   = 0;
                rd_cnt   = 0;
            end
            if (wr_en)
            begin
                check_true(init_done, "write strobe while init_done low");
                check_true(!ref_busy_q, "write strobe after a refresh cycle");
                check_true(rd_cnt == 0, "write strobe after reads began");
                check_true(busy, "busy low during a write strobe");
                check_val("wr_addr", 32'(wr_cnt), 32'(wr_addr));
                check_val("wr_data", pattern_for(wr_cnt, cur_odd), wr_data);
                mem[wr_addr[7:0]] = wr_data;
                wr_cnt++;
            end
            if (rd_en)
            begin
                check_true(init_done, "read strobe while init_done low");
                check_true(!ref_busy_q, "read strobe after a refresh cycle");
                check_true(wr_cnt == `SDR_TEST_WORDS, "read strobe before writes ended");
                check_true(busy, "busy low during a read strobe");
                check_val("rd_addr", 32'(rd_cnt), 32'(rd_addr));
                rq_addr.push_back(int'(rd_addr));
                // in-order return, latency 2 to 9
                lat      = 2 + take_bits(3);
                last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
                rq_due.push_back(last_due);
                rd_cnt++;
            end
            if (rd_valid)
                last_rv_cyc = cyc;
            if (done)
            begin
                check_val("wr_count", `SDR_TEST_WORDS, 32'(wr_cnt));
                check_val("rd_count", `SDR_TEST_WORDS, 32'(rd_cnt));
                check_val("timed_out", 32'(exp_timeout), 32'(timed_out));
                check_val("pass_ok",
                          32'(exp_data_err == 0 && exp_tag_err == 0 && !exp_timeout),
                          32'(pass_ok));
                if (!exp_timeout)
                begin
                    check_val("data_err_cnt", 32'(exp_data_err), 32'(data_err_cnt));
                    check_val("tag_err_cnt", 32'(exp_tag_err), 32'(tag_err_cnt));
                    // capture, compare, chk_last, done
                    check_val("done_latency", 3, 32'(cyc - last_rv_cyc));
                    if (exp_data_err + exp_tag_err > 0)
                        check_val("first_err_addr", 32'(exp_first), 32'(first_err_addr));
                end
                pass_done = 1'b1;
            end
        end
        ref_busy_q = ref_busy;

        #1;
        rd_valid = 1'b0;
        if (rq_due.size() > 0 && rq_due[0] <= cyc)
        begin
            void'(rq_due.pop_front());
            a    = rq_addr.pop_front();
            d    = mem[a[7:0]];
            drop = (mode == 3) && (a == 100);
            // corrupted words sit at 5 and 77
            if (mode == 1 && (a == 5 || a == 77))
                d = d ^ 32'h0000_0001;
            if (mode == 2 && (a == 5 || a == 77))
                d = d ^ 32'h0001_0000;
            rd_data  = d;
            rd_valid = !drop;
        end
        // refresh windows of 1 to 4 cycles
        if (ref_left > 0)
        begin
            ref_left--;
            ref_busy = 1'b1;
        end
        else if (arst_n && take_bits(4) == 0)
        begin
            ref_left = take_bits(2);
            ref_busy = 1'b1;
        end
        else
            ref_busy = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic run_pass(int m, int init_delay);
        bit got;
        mode         = m;
        exp_data_err = (m == 1) ? 2 : 0;
        exp_tag_err  = (m == 2) ? 2 : 0;
        exp_first    = 5;
        exp_timeout  = (m == 3);
        pass_done    = 1'b0;
        got          = 1'b0;
        @(posedge Clk);
        #1 start = 1'b1;
        @(posedge Clk);
        #1 start = 1'b0;
        if (init_delay > 0)
        begin
            repeat (init_delay) @(posedge Clk);
            #1 init_done = 1'b1;
        end
        for (int i = 0; i < 8000 && !got; i++)
        begin
            @(posedge Clk);
            #1 got = pass_done;
        end
        if (!got)
        begin
            errors++;
            aborted = 1'b1;
            $display("error: done never came for pass mode %0d", m);
        end
    endtask

    initial
    begin
        bit up;
        lfsr      = 32'ha641_ee6f;
        start     = 1'b0;
        init_done = 1'b0;
        ref_busy  = 1'b0;
        rd_valid  = 1'b0;
        rd_data   = '0;
        errors    = 0;
        cyc       = 0;
        last_due  = 0;
        ref_left  = 0;
        mode      = 0;
        next_odd  = 1'b0;
        aborted   = 1'b0;
        up        = 1'b0;
        for (int i = 0; i < `SDR_TEST_WORDS; i++)
            mem[i] = {~i[15:0], i[15:0]} ^ 32'h5a5a_0000;
        for (int i = 0; i < 50 && !up; i++)
        begin
            @(posedge Clk);
            up = arst_n;
        end
        if (!up)
        begin
            errors++;
            aborted = 1'b1;
            $display("error: reset was never released");
        end
        else
        begin
            @(posedge Clk);
            check_true(!wr_en && !rd_en && !busy && !done, "outputs active after reset");
        end
        // init wait exercised on the first pass only
        if (!aborted)
            run_pass(0, 20);
        if (!aborted)
            run_pass(0, 0);
        if (!aborted)
            run_pass(1, 0);
        if (!aborted)
            run_pass(2, 0);
        if (!aborted)
            run_pass(3, 0);
        if (!aborted)
            run_pass(0, 0);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
    output logic Clk,
    output logic arst_n
);
    // 4 ns period
    initial
    begin
        Clk = 1'b0;
        forever
            #2 Clk = ~Clk;
    end

    // reset held for 8 rising edges, released off the edge
    initial
    begin
        arst_n = 1'b0;
        repeat (8) @(posedge Clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/sdr_test_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdr_test_consts.svh"

module sdr_test_top
(
    input  wire                        Clk,
    input  wire                        arst_n,
    input  wire                        start,
    input  wire                        init_done,
    input  wire                        ref_busy,
    input  wire                        rd_valid,
    input  wire  [`SDR_DATA_WIDTH-1:0] rd_data,
    output logic                       wr_en,
    output logic [`SDR_ADDR_WIDTH-1:0] wr_addr,
    output logic [`SDR_DATA_WIDTH-1:0] wr_data,
    output logic                       rd_en,
    output logic [`SDR_ADDR_WIDTH-1:0] rd_addr,
    output logic                       busy,
    output logic                       done,
    output logic                       pass_ok,
    output logic [`SDR_CNT_WIDTH-1:0]  data_err_cnt,
    output logic [`SDR_CNT_WIDTH-1:0]  tag_err_cnt,
    output logic [`SDR_ADDR_WIDTH-1:0] first_err_addr,
    output logic                       timed_out
);
    // phase levels and handback strobes
    logic wr_go;
    logic rd_go;
    logic pass_odd;
    logic chk_clear;
    logic wr_last;
    logic rd_last;
    logic chk_last;
    logic chk_err_any;

    sdr_test_ctrl u_ctrl
    (
        .Clk(Clk), .arst_n(arst_n), .start(start), .init_done(init_done),
        .wr_last(wr_last), .rd_last(rd_last), .chk_last(chk_last),
        .chk_err_any(chk_err_any), .wr_go(wr_go), .rd_go(rd_go),
        .pass_odd(pass_odd), .chk_clear(chk_clear), .busy(busy), .done(done),
        .pass_ok(pass_ok), .timed_out(timed_out)
    );

    sdr_pattern_gen u_pattern_gen
    (
        .Clk(Clk), .arst_n(arst_n), .wr_go(wr_go), .ref_busy(ref_busy),
        .pass_odd(pass_odd), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_last(wr_last)
    );

    sdr_read_issue u_read_issue
    (
        .Clk(Clk), .arst_n(arst_n), .rd_go(rd_go), .ref_busy(ref_busy),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_last(rd_last)
    );

    sdr_read_check u_read_check
    (
        .Clk(Clk), .arst_n(arst_n), .chk_clear(chk_clear), .pass_odd(pass_odd),
        .rd_valid(rd_valid), .rd_data(rd_data), .chk_last(chk_last),
        .chk_err_any(chk_err_any), .data_err_cnt(data_err_cnt),
        .tag_err_cnt(tag_err_cnt), .first_err_addr(first_err_addr)
    );

endmodule

`default_nettype wire

//--- verilog/sdr_read_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdr_test_consts.svh"

module sdr_read_check
(
    input  wire                        Clk,
    input  wire                        arst_n,
    input  wire                        chk_clear,
    input  wire                        pass_odd,
    input  wire                        rd_valid,
    input  wire  [`SDR_DATA_WIDTH-1:0] rd_data,
    output logic                       chk_last,
    output logic                       chk_err_any,
    output logic [`SDR_CNT_WIDTH-1:0]  data_err_cnt,
    output logic [`SDR_CNT_WIDTH-1:0]  tag_err_cnt,
    output logic [`SDR_ADDR_WIDTH-1:0] first_err_addr
);
    import sdr_test_pkg::*;

    localparam logic [`SDR_CNT_WIDTH-1:0] words_full = `SDR_CNT_WIDTH'(`SDR_TEST_WORDS);
    localparam logic [`SDR_CNT_WIDTH-1:0] last_idx   = `SDR_CNT_WIDTH'(`SDR_TEST_WORDS - 1);

    // returns arrive in request order, so the count is the address
    logic [`SDR_CNT_WIDTH-1:0] rx_cnt;
    logic [`SDR_CNT_WIDTH-1:0] exp_idx;
    logic                      valid_q;
    logic                      last_q;
    logic                      err_seen;
    logic                      tag_bad;
    logic                      seq_bad;
    pattern_word_t             word_q;
    pattern_word_t             exp_word;

    // expected word for the registered return
    always_comb
    begin
        exp_word.fields.addr_tag = exp_idx[`SDR_TAG_WIDTH-1:0];
        exp_word.fields.seq      = pass_odd ? ~exp_idx[`SDR_TAG_WIDTH-1:0]
                                            :  exp_idx[`SDR_TAG_WIDTH-1:0];
    end

    // wrong tag first, otherwise any other difference sits in seq
    assign tag_bad = word_q.fields.addr_tag != exp_word.fields.addr_tag;
    assign seq_bad = !tag_bad && (word_q.raw != exp_word.raw);

    assign chk_err_any = (data_err_cnt != '0) || (tag_err_cnt != '0);

    //////////////////////////////////////////////////////////////////////
    // capture stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk)
    begin
        if (rd_valid)
        begin
            word_q.raw <= rd_data;
            exp_idx    <= rx_cnt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare stage, counts and first failing address
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_cnt         <= '0;
            valid_q        <= 1'b0;
            last_q         <= 1'b0;
            chk_last       <= 1'b0;
            data_err_cnt   <= '0;
            tag_err_cnt    <= '0;
            err_seen       <= 1'b0;
            first_err_addr <= '0;
        end
        else if (chk_clear)
        begin
            rx_cnt         <= '0;
            valid_q        <= 1'b0;
            last_q         <= 1'b0;
            chk_last       <= 1'b0;
            data_err_cnt   <= '0;
            tag_err_cnt    <= '0;
            err_seen       <= 1'b0;
            first_err_addr <= '0;
        end
        else
        begin
            valid_q  <= rd_valid;
            last_q   <= rd_valid && (rx_cnt == last_idx);
            chk_last <= last_q;
            if (rd_valid)
                rx_cnt <= rx_cnt + 1'b1;
            // saturating counts
            if (valid_q && tag_bad && (tag_err_cnt != '1))
                tag_err_cnt <= tag_err_cnt + 1'b1;
            if (valid_q && seq_bad && (data_err_cnt != '1))
                data_err_cnt <= data_err_cnt + 1'b1;
            if (valid_q && (tag_bad || seq_bad) && !err_seen)
            begin
                err_seen       <= 1'b1;
                first_err_addr <= {{(`SDR_ADDR_WIDTH - `SDR_CNT_WIDTH){1'b0}}, exp_idx};
            end
        end
    end

    // no return beyond the pass length until the next clear
    a_no_extra_return: assert property (@(posedge Clk) disable iff (!arst_n)
        rd_valid |-> (rx_cnt < words_full));

endmodule

`default_nettype wire

//--- verilog/sdr_read_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdr_test_consts.svh"

module sdr_read_issue
(
    input  wire                        Clk,
    input  wire                        arst_n,
    input  wire                        rd_go,
    input  wire                        ref_busy,
    output logic                       rd_en,
    output logic [`SDR_ADDR_WIDTH-1:0] rd_addr,
    output logic                       rd_last
);
    localparam logic [`SDR_CNT_WIDTH-1:0] last_idx = `SDR_CNT_WIDTH'(`SDR_TEST_WORDS - 1);

    logic                      rd_go_q;
    logic                      active;
    logic                      issue;
    logic [`SDR_CNT_WIDTH-1:0] cnt;

    // one read per cycle unless refresh holds us off
    assign issue = active && rd_go && !ref_busy;

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_go_q <= 1'b0;
            active  <= 1'b0;
            cnt     <= '0;
            rd_en   <= 1'b0;
            rd_last <= 1'b0;
        end
        else
        begin
            rd_go_q <= rd_go;
            rd_en   <= issue;
            rd_last <= issue && (cnt == last_idx);
            // restart from address 0 on each read phase
            if (rd_go && !rd_go_q)
            begin
                cnt    <= '0;
                active <= 1'b1;
            end
            else if (!rd_go)
                active <= 1'b0;
            else if (issue)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == last_idx)
                    active <= 1'b0;
            end
        end
    end

    // address valid with the strobe
    always_ff @(posedge Clk)
    begin
        if (issue)
            rd_addr <= {{(`SDR_ADDR_WIDTH - `SDR_CNT_WIDTH){1'b0}}, cnt};
    end

endmodule

`default_nettype wire

//--- verilog/sdr_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdr_test_consts.svh"

module sdr_pattern_gen
(
    input  wire                        Clk,
    input  wire                        arst_n,
    input  wire                        wr_go,
    input  wire                        ref_busy,
    input  wire                        pass_odd,
    output logic                       wr_en,
    output logic [`SDR_ADDR_WIDTH-1:0] wr_addr,
    output logic [`SDR_DATA_WIDTH-1:0] wr_data,
    output logic                       wr_last
);
    import sdr_test_pkg::*;

    localparam logic [`SDR_CNT_WIDTH-1:0] last_idx = `SDR_CNT_WIDTH'(`SDR_TEST_WORDS - 1);

    logic                      wr_go_q;
    // set on wr_go rising, cleared after the final word
    logic                      active;
    logic                      issue;
    logic [`SDR_CNT_WIDTH-1:0] cnt;
    pattern_word_t             word_next;

    // refresh pauses the counter, it resumes where it stopped
    assign issue = active && wr_go && !ref_busy;

    // tag is the low address bits, seq follows pass parity
    always_comb
    begin
        word_next.fields.addr_tag = cnt[`SDR_TAG_WIDTH-1:0];
        word_next.fields.seq      = pass_odd ? ~cnt[`SDR_TAG_WIDTH-1:0]
                                             :  cnt[`SDR_TAG_WIDTH-1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // write address counter and strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_go_q <= 1'b0;
            active  <= 1'b0;
            cnt     <= '0;
            wr_en   <= 1'b0;
            wr_last <= 1'b0;
        end
        else
        begin
            wr_go_q <= wr_go;
            wr_en   <= issue;
            wr_last <= issue && (cnt == last_idx);
            if (wr_go && !wr_go_q)
            begin
                cnt    <= '0;
                active <= 1'b1;
            end
            else if (!wr_go)
                active <= 1'b0;
            else if (issue)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == last_idx)
                    active <= 1'b0;
            end
        end
    end

    // address and data travel with the strobe
    always_ff @(posedge Clk)
    begin
        if (issue)
        begin
            wr_addr <= {{(`SDR_ADDR_WIDTH - `SDR_CNT_WIDTH){1'b0}}, cnt};
            wr_data <= word_next.raw;
        end
    end

    // refresh seen last cycle means no write now
    a_no_wr_in_refresh: assert property (@(posedge Clk) disable iff (!arst_n)
        wr_en |-> !$past(ref_busy));

endmodule

`default_nettype wire

//--- verilog/sdr_test_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdr_test_consts.svh"

module sdr_test_ctrl
(
    input  wire  Clk,
    input  wire  arst_n,
    input  wire  start,
    input  wire  init_done,
    input  wire  wr_last,
    input  wire  rd_last,
    input  wire  chk_last,
    input  wire  chk_err_any,
    output logic wr_go,
    output logic rd_go,
    output logic pass_odd,
    output logic chk_clear,
    output logic busy,
    output logic done,
    output logic pass_ok,
    output logic timed_out
);
    import sdr_test_pkg::*;

    localparam int drain_w = $clog2(`SDR_DRAIN_TIMEOUT);
    localparam logic [drain_w-1:0] drain_last = drain_w'(`SDR_DRAIN_TIMEOUT - 1);

    test_state_t        state;
    logic               start_acc;
    // parity handed out at the next accepted start
    logic               next_odd;
    logic [drain_w-1:0] drain_cnt;

    // start only counts between passes
    assign start_acc = start && ((state == st_idle) || (state == st_verdict));

    // phase levels straight off the state register
    assign wr_go = (state == st_write);
    assign rd_go = (state == st_read);
    assign busy  = (state != st_idle) && (state != st_verdict);

    //////////////////////////////////////////////////////////////////////
    // pass sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= st_idle;
            next_odd  <= 1'b0;
            pass_odd  <= 1'b0;
            chk_clear <= 1'b0;
            done      <= 1'b0;
            pass_ok   <= 1'b0;
            timed_out <= 1'b0;
            drain_cnt <= '0;
        end
        else
        begin
            chk_clear <= start_acc;
            done      <= 1'b0;
            // new pass: flip parity, drop old verdict
            if (start_acc)
            begin
                pass_odd  <= next_odd;
                next_odd  <= ~next_odd;
                pass_ok   <= 1'b0;
                timed_out <= 1'b0;
            end
            case (state)
                st_idle, st_verdict:
                    if (start_acc)
                        state <= st_wait_init;
                st_wait_init:
                    if (init_done)
                        state <= st_write;
                st_write:
                    if (wr_last)
                        state <= st_read;
                st_read:
                    if (rd_last)
                    begin
                        state     <= st_drain;
                        drain_cnt <= '0;
                    end
                st_drain:
                    // last compare wins over the timeout in the same cycle
                    if (chk_last)
                    begin
                        done    <= 1'b1;
                        pass_ok <= !chk_err_any;
                        state   <= st_verdict;
                    end
                    else if (drain_cnt == drain_last)
                    begin
                        done      <= 1'b1;
                        timed_out <= 1'b1;
                        state     <= st_verdict;
                    end
                    else
                        drain_cnt <= drain_cnt + 1'b1;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // write and read phases never overlap
    a_go_exclusive: assert property (@(posedge Clk) disable iff (!arst_n)
        !(wr_go && rd_go));

endmodule

`default_nettype wire

//--- verilog/sdr_test_pkg.sv
`default_nettype none

`include "sdr_test_consts.svh"

package sdr_test_pkg;

    // sequencer states, one pass runs top to bottom
    typedef enum logic [2:0]
    {
        st_idle      = 3'd0,
        st_wait_init = 3'd1,
        st_write     = 3'd2,
        st_read      = 3'd3,
        st_drain     = 3'd4,
        st_verdict   = 3'd5
    } test_state_t;

    // tag in the upper half, sequence in the lower half
    typedef struct packed
    {
        logic [`SDR_TAG_WIDTH-1:0] addr_tag;
        logic [`SDR_TAG_WIDTH-1:0] seq;
    } pattern_fields_t;

    // one port word, seen whole or split into its two fields
    typedef union packed
    {
        logic [`SDR_DATA_WIDTH-1:0] raw;
        pattern_fields_t            fields;
    } pattern_word_t;

endpackage

`default_nettype wire

//--- include/sdr_test_consts.svh
`ifndef SDR_TEST_CONSTS_SVH
`define SDR_TEST_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// application port geometry
//////////////////////////////////////////////////////////////////////

// application address width, words
`define SDR_ADDR_WIDTH 22

// one data word on the port
`define SDR_DATA_WIDTH 32

// address tag and sequence field, half a word each
`define SDR_TAG_WIDTH 16

//////////////////////////////////////////////////////////////////////
// test sizing
//////////////////////////////////////////////////////////////////////

// words written and read back per pass
`define SDR_TEST_WORDS 256

// word counters and error counters
`define SDR_CNT_WIDTH 16

// cycles from last read request until the verdict is forced
`define SDR_DRAIN_TIMEOUT 512

`endif
